// File: rtl/rtc_field_pkg.sv
package rtc_field_pkg;

    localparam int data_w      = 8;
    localparam int rtc_addr_w  = 8;
    localparam int field_count = 12;

    typedef enum logic [3:0] {
        format,
        seconds,
        minutes,
        hours,
        date,
        month,
        year,
        weekday,
        week_num,
        tmr_seconds,
        tmr_minutes,
        tmr_hours
    } field_t;

    localparam logic [data_w-1:0] fmt_12h = 8'h10;
    localparam logic [data_w-1:0] fmt_24h = 8'h00;

    // rtc register map, indexed by field_t
    localparam logic [rtc_addr_w-1:0] field_addr [field_count] = '{
        8'h00, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25,
        8'h26, 8'h27, 8'h28, 8'h41, 8'h42, 8'h43
    };

    // format limits span its two codes
    localparam logic [data_w-1:0] field_min [field_count] = '{
        fmt_24h, 8'd0, 8'd0, 8'd0, 8'd1, 8'd1,
        8'd0, 8'd1, 8'd1, 8'd0, 8'd0, 8'd0
    };

    localparam logic [data_w-1:0] field_max [field_count] = '{
        fmt_12h, 8'd59, 8'd59, 8'd23, 8'd31, 8'd12,
        8'd99, 8'd7, 8'd53, 8'd59, 8'd59, 8'd23
    };

endpackage

// File: rtl/edit_bus_pkg.sv
package edit_bus_pkg;

    localparam int adr_w = 4; // holds a field_t

    typedef enum logic [2:0] {
        op_none,
        op_inc,
        op_dec,
        op_left,
        op_right
    } key_op_t;

    typedef enum logic [1:0] {
        nav_idle,
        nav_rd_cycle,
        nav_wr_cycle
    } nav_state_t;

    typedef enum logic [1:0] {
        drn_idle,
        drn_rd_cycle,
        drn_present
    } drain_state_t;

endpackage

// File: rtl/field_bus_if.sv
`timescale 1ns/10ps

interface field_bus_if;

    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [edit_bus_pkg::adr_w-1:0]   adr;
    logic [rtc_field_pkg::data_w-1:0] dat_w;
    logic [rtc_field_pkg::data_w-1:0] dat_r;
    logic                             ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // read only master, never writes
    modport reader (
        output cyc, stb, adr,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

    modport slave_ro (
        input  cyc, stb, adr,
        output dat_r, ack
    );

endinterface

// File: rtl/field_navigator.sv
`timescale 1ns/10ps

module field_navigator (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  key_inc,
    input  logic                  key_dec,
    input  logic                  key_left,
    input  logic                  key_right,
    input  logic                  timer_mode,
    output logic                  busy,
    output rtc_field_pkg::field_t sel_field,
    field_bus_if.master           bus
);

    logic [3:0]              key_q;     // inc, dec, left, right
    logic [3:0]              key_prev;
    logic [3:0]              key_rise;
    logic                    mode_q;
    logic                    mode_prev;
    logic                    edit_up;
    edit_bus_pkg::key_op_t   op;
    edit_bus_pkg::nav_state_t state;

    // next field in the ring, fwd selects right
    function automatic rtc_field_pkg::field_t step_field(
        input rtc_field_pkg::field_t f,
        input logic                  fwd
    );
        rtc_field_pkg::field_t nxt;
        if (fwd) begin
            if (f == rtc_field_pkg::week_num)
                nxt = rtc_field_pkg::format;
            else if (f == rtc_field_pkg::tmr_hours)
                nxt = rtc_field_pkg::tmr_seconds;
            else
                nxt = rtc_field_pkg::field_t'(f + 4'd1);
        end else begin
            if (f == rtc_field_pkg::format)
                nxt = rtc_field_pkg::week_num;
            else if (f == rtc_field_pkg::tmr_seconds)
                nxt = rtc_field_pkg::tmr_hours;
            else
                nxt = rtc_field_pkg::field_t'(f - 4'd1);
        end
        return nxt;
    endfunction

    function automatic logic [rtc_field_pkg::data_w-1:0] edit_value(
        input rtc_field_pkg::field_t             f,
        input logic                              up,
        input logic [rtc_field_pkg::data_w-1:0]  cur
    );
        logic [rtc_field_pkg::data_w-1:0] lo;
        logic [rtc_field_pkg::data_w-1:0] hi;
        logic [rtc_field_pkg::data_w-1:0] res;
        lo = rtc_field_pkg::field_min[f];
        hi = rtc_field_pkg::field_max[f];
        if (f == rtc_field_pkg::format)
            res = up ? rtc_field_pkg::fmt_12h : rtc_field_pkg::fmt_24h; // jump to code
        else if (up)
            res = (cur >= hi) ? lo : cur + 8'd1;
        else
            res = (cur <= lo) ? hi : cur - 8'd1;
        return res;
    endfunction

    assign key_rise = key_q & ~key_prev;

    always_comb begin
        op = edit_bus_pkg::op_none;
        if (state == edit_bus_pkg::nav_idle && $onehot(key_rise)) begin
            if (key_rise[3])
                op = edit_bus_pkg::op_inc;
            else if (key_rise[2])
                op = edit_bus_pkg::op_dec;
            else if (key_rise[1])
                op = edit_bus_pkg::op_left;
            else
                op = edit_bus_pkg::op_right;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            key_q     <= '0;
            key_prev  <= '0;
            mode_q    <= 1'b0;
            mode_prev <= 1'b0;
            sel_field <= rtc_field_pkg::format;
        end else begin
            key_q     <= {key_inc, key_dec, key_left, key_right};
            key_prev  <= key_q;
            mode_q    <= timer_mode;
            mode_prev <= mode_q;
            if (mode_q && !mode_prev)
                sel_field <= rtc_field_pkg::tmr_seconds;
            else if (!mode_q && mode_prev)
                sel_field <= rtc_field_pkg::format;
            else if (op == edit_bus_pkg::op_right)
                sel_field <= step_field(sel_field, 1'b1);
            else if (op == edit_bus_pkg::op_left)
                sel_field <= step_field(sel_field, 1'b0);
        end
    end

    // read-modify-write over the edit bus
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= edit_bus_pkg::nav_idle;
            busy    <= 1'b0;
            edit_up <= 1'b0;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            bus.we  <= 1'b0;
        end else begin
            case (state)
                edit_bus_pkg::nav_idle: begin
                    if (op == edit_bus_pkg::op_inc || op == edit_bus_pkg::op_dec) begin
                        edit_up <= (op == edit_bus_pkg::op_inc);
                        bus.adr <= sel_field;
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we  <= 1'b0;
                        busy    <= 1'b1;
                        state   <= edit_bus_pkg::nav_rd_cycle;
                    end
                end
                edit_bus_pkg::nav_rd_cycle: begin
                    if (bus.ack) begin
                        bus.cyc   <= 1'b0;
                        bus.stb   <= 1'b0;
                        bus.dat_w <= edit_value(rtc_field_pkg::field_t'(bus.adr), edit_up,
                                                bus.dat_r);
                        state     <= edit_bus_pkg::nav_wr_cycle;
                    end
                end
                edit_bus_pkg::nav_wr_cycle: begin
                    if (!bus.cyc) begin // one idle cycle after the read
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we  <= 1'b1;
                    end else if (bus.ack) begin
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        bus.we  <= 1'b0;
                        busy    <= 1'b0;
                        state   <= edit_bus_pkg::nav_idle;
                    end
                end
                default: state <= edit_bus_pkg::nav_idle;
            endcase
        end
    end

endmodule

// File: rtl/field_register_bank.sv
`timescale 1ns/10ps

module field_register_bank (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_valid,
    input  rtc_field_pkg::field_t                 load_field,
    input  logic [rtc_field_pkg::data_w-1:0]      load_data,
    field_bus_if.slave                            edit,
    field_bus_if.slave_ro                         drain,
    output logic [rtc_field_pkg::field_count-1:0] dirty
);

    logic [rtc_field_pkg::data_w-1:0]      field_q [rtc_field_pkg::field_count];
    logic                                  edit_rd;
    logic                                  edit_wr;
    logic                                  drain_rd;
    logic [rtc_field_pkg::field_count-1:0] set_vec;
    logic [rtc_field_pkg::field_count-1:0] clr_vec;

    assign edit_rd  = edit.cyc && edit.stb && !edit.we && !edit.ack;
    assign edit_wr  = edit.cyc && edit.stb && edit.we && !edit.ack && !load_valid; // load wins
    assign drain_rd = drain.cyc && drain.stb && !drain.ack;

    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (edit_wr)
            set_vec[edit.adr] = 1'b1;
        if (drain_rd)
            clr_vec[drain.adr] = 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rtc_field_pkg::field_count; i++)
                field_q[i] <= rtc_field_pkg::field_min[i];
        end else begin
            if (load_valid)
                field_q[load_field] <= load_data;
            if (edit_wr)
                field_q[edit.adr] <= edit.dat_w;
        end
    end

    // a same-cycle edit write keeps the flag set
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            dirty <= '0;
        else
            dirty <= (dirty & ~clr_vec) | set_vec;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edit.ack  <= 1'b0;
            drain.ack <= 1'b0;
        end else begin
            edit.ack  <= edit_rd || edit_wr;
            drain.ack <= drain_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (edit_rd)
            edit.dat_r <= field_q[edit.adr];
        if (drain_rd)
            drain.dat_r <= field_q[drain.adr];
    end

endmodule

// File: rtl/rtc_write_port.sv
`timescale 1ns/10ps

module rtc_write_port (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [rtc_field_pkg::field_count-1:0] dirty,
    field_bus_if.reader                           bus,
    input  logic                                  rtc_ready,
    output logic                                  rtc_write,
    output logic [rtc_field_pkg::rtc_addr_w-1:0]  rtc_address,
    output logic [rtc_field_pkg::data_w-1:0]      rtc_data
);

    logic [edit_bus_pkg::adr_w-1:0] pick;
    edit_bus_pkg::drain_state_t     state;

    // lowest set dirty bit goes first
    always_comb begin
        pick = '0;
        for (int i = rtc_field_pkg::field_count - 1; i >= 0; i--) begin
            if (dirty[i])
                pick = edit_bus_pkg::adr_w'(i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= edit_bus_pkg::drn_idle;
            bus.cyc   <= 1'b0;
            bus.stb   <= 1'b0;
            rtc_write <= 1'b0;
        end else begin
            case (state)
                edit_bus_pkg::drn_idle: begin
                    if (|dirty) begin
                        bus.adr <= pick;
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        state   <= edit_bus_pkg::drn_rd_cycle;
                    end
                end
                edit_bus_pkg::drn_rd_cycle: begin
                    if (bus.ack) begin
                        bus.cyc     <= 1'b0;
                        bus.stb     <= 1'b0;
                        rtc_address <= rtc_field_pkg::field_addr[bus.adr];
                        rtc_data    <= bus.dat_r;
                        rtc_write   <= 1'b1;
                        state       <= edit_bus_pkg::drn_present;
                    end
                end
                edit_bus_pkg::drn_present: begin
                    if (rtc_ready) begin // transfer taken
                        rtc_write <= 1'b0;
                        state     <= edit_bus_pkg::drn_idle;
                    end
                end
                default: state <= edit_bus_pkg::drn_idle;
            endcase
        end
    end

endmodule

// File: rtl/rtc_edit_top.sv
`timescale 1ns/10ps

module rtc_edit_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 key_inc,
    input  logic                                 key_dec,
    input  logic                                 key_left,
    input  logic                                 key_right,
    input  logic                                 timer_mode,
    input  logic                                 load_valid,
    input  rtc_field_pkg::field_t                load_field,
    input  logic [rtc_field_pkg::data_w-1:0]     load_data,
    input  logic                                 rtc_ready,
    output logic                                 busy,
    output logic [rtc_field_pkg::rtc_addr_w-1:0] sel_address,
    output logic                                 rtc_write,
    output logic [rtc_field_pkg::rtc_addr_w-1:0] rtc_address,
    output logic [rtc_field_pkg::data_w-1:0]     rtc_data
);

    rtc_field_pkg::field_t                 sel_field;
    logic [rtc_field_pkg::field_count-1:0] dirty;

    field_bus_if edit_bus ();
    field_bus_if drain_bus ();

    assign sel_address = rtc_field_pkg::field_addr[sel_field];

    field_navigator u_navigator (
        .clk        (clk),
        .reset      (reset),
        .key_inc    (key_inc),
        .key_dec    (key_dec),
        .key_left   (key_left),
        .key_right  (key_right),
        .timer_mode (timer_mode),
        .busy       (busy),
        .sel_field  (sel_field),
        .bus        (edit_bus)
    );

    field_register_bank u_bank (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_field (load_field),
        .load_data  (load_data),
        .edit       (edit_bus),
        .drain      (drain_bus),
        .dirty      (dirty)
    );

    rtc_write_port u_write_port (
        .clk         (clk),
        .reset       (reset),
        .dirty       (dirty),
        .bus         (drain_bus),
        .rtc_ready   (rtc_ready),
        .rtc_write   (rtc_write),
        .rtc_address (rtc_address),
        .rtc_data    (rtc_data)
    );

endmodule

// File: sim/rtc_edit_properties.sv
`timescale 1ns/10ps

module rtc_edit_properties (
    input logic        clk,
    input logic        reset,
    input logic        stb,
    input logic        ack,
    input logic        hold_valid,
    input logic        hold_ready,
    input logic [15:0] hold_data
);

    int fails = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            $error("bus ack lasted more than one cycle");
            fails++;
        end

    ack_with_stb: assert property (@(posedge clk) disable iff (reset) ack |-> stb)
        else begin
            $error("bus ack without stb");
            fails++;
        end

    // offered transfer must not move before it is taken
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        hold_valid && !hold_ready |=> hold_valid && $stable(hold_data))
        else begin
            $error("held transfer changed before it was taken");
            fails++;
        end

endmodule

bind field_register_bank rtc_edit_properties props (
    .clk        (clk),
    .reset      (reset),
    .stb        (edit.stb),
    .ack        (edit.ack),
    .hold_valid (edit.stb),
    .hold_ready (edit.ack),
    .hold_data  ({3'b000, edit.we, edit.adr, edit.we ? edit.dat_w : 8'h00})
);

bind rtc_write_port rtc_edit_properties props (
    .clk        (clk),
    .reset      (reset),
    .stb        (bus.stb),
    .ack        (bus.ack),
    .hold_valid (rtc_write),
    .hold_ready (rtc_ready),
    .hold_data  ({rtc_address, rtc_data})
);

// File: sim/rtc_edit_tb.sv
`timescale 1ns/10ps

module rtc_edit_tb;

    localparam int max_steps  = 64;
    localparam int wait_limit = 200;

    logic                  clk;
    logic                  reset;
    logic                  key_inc;
    logic                  key_dec;
    logic                  key_left;
    logic                  key_right;
    logic                  timer_mode;
    logic                  load_valid;
    rtc_field_pkg::field_t load_field;
    logic [7:0]            load_data;
    logic                  rtc_ready;
    logic                  busy;
    logic [7:0]            sel_address;
    logic                  rtc_write;
    logic [7:0]            rtc_address;
    logic [7:0]            rtc_data;

    logic [31:0] steps [max_steps];
    logic [15:0] sent_q [$];    // finished rtc transfers, {address, data}
    logic        hold_ready;
    integer      seed = 32'hda86;
    int          errors = 0;
    int          tests = 0;
    int          step_errors;

    rtc_edit_top UUT (
        .clk         (clk),
        .reset       (reset),
        .key_inc     (key_inc),
        .key_dec     (key_dec),
        .key_left    (key_left),
        .key_right   (key_right),
        .timer_mode  (timer_mode),
        .load_valid  (load_valid),
        .load_field  (load_field),
        .load_data   (load_data),
        .rtc_ready   (rtc_ready),
        .busy        (busy),
        .sel_address (sel_address),
        .rtc_write   (rtc_write),
        .rtc_address (rtc_address),
        .rtc_data    (rtc_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure, parked low during a hold
    initial begin
        int r;
        rtc_ready = 1'b0;
        forever begin
            @(posedge clk);
            r = $random(seed);
            #2 rtc_ready = !hold_ready && r[0];
        end
    end

    always @(negedge clk) begin
        if (!reset && rtc_write && rtc_ready)
            sent_q.push_back({rtc_address, rtc_data}); // completes on next edge
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            step_errors++;
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("timeout at %0t: busy never went to %0b", $time, level);
            step_errors++;
        end
    endtask

    task automatic wait_sent(output logic [15:0] word);
        int n;
        n = 0;
        while (sent_q.size() == 0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (sent_q.size() == 0) begin
            $display("timeout at %0t: no rtc write arrived", $time);
            step_errors++;
            word = '0;
        end else begin
            word = sent_q.pop_front();
        end
    endtask

    task automatic press_key(input logic [3:0] code);
        {key_inc, key_dec, key_left, key_right} = 4'b1000 >> (code - 4'd1);
        tick(1);
        {key_inc, key_dec, key_left, key_right} = 4'b0000;
    endtask

    task automatic run_step(input logic [31:0] s);
        logic [3:0]  kind;
        logic [3:0]  opnd;
        logic [7:0]  val;
        logic [7:0]  exp_adr;
        logic [7:0]  exp_dat;
        logic [15:0] word;
        {kind, opnd, val, exp_adr, exp_dat} = s;
        case (kind)
            4'h1: begin
                load_valid = 1'b1;
                load_field = rtc_field_pkg::field_t'(opnd);
                load_data  = val;
                tick(1);
                load_valid = 1'b0;
                tick(6);
                assert (!rtc_write && sent_q.size() == 0) else begin
                    $display("load at %0t started an rtc write", $time);
                    step_errors++;
                end
            end
            4'h2: begin
                press_key(opnd);
                if (opnd == 4'd1 || opnd == 4'd2) begin
                    wait_busy(1'b1);
                    wait_busy(1'b0);
                    if (!hold_ready) begin
                        wait_sent(word);
                        check_value("rtc_address", word[15:8], exp_adr);
                        check_value("rtc_data", word[7:0], exp_dat);
                    end
                end else begin
                    tick(2);
                    check_value("sel_address", sel_address, exp_adr);
                end
            end
            4'h3: begin
                timer_mode = opnd[0];
                tick(3);
                check_value("sel_address", sel_address, exp_adr);
            end
            4'h4: hold_ready = 1'b1;
            4'h5: begin
                hold_ready = 1'b0;
                wait_sent(word);
                check_value("rtc_address", word[15:8], exp_adr);
                check_value("rtc_data", word[7:0], exp_dat);
            end
            default: begin
                $display("unknown step kind %0h in the data file", kind);
                step_errors++;
            end
        endcase
        tick(1);
    endtask

    initial begin
        int i;
        reset      = 1'b1;
        key_inc    = 1'b0;
        key_dec    = 1'b0;
        key_left   = 1'b0;
        key_right  = 1'b0;
        timer_mode = 1'b0;
        load_valid = 1'b0;
        load_field = rtc_field_pkg::format;
        load_data  = 8'h00;
        hold_ready = 1'b0;
        for (i = 0; i < max_steps; i++)
            steps[i] = '0;
        $readmemh("sim/edit_testdata.txt", steps);
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        tick(2);
        i = 0;
        while (i < max_steps && steps[i][31:28] != 4'h0) begin
            step_errors = 0;
            run_step(steps[i]);
            tests++;
            errors += step_errors;
            $display("test %0d kind %0h %s", i, steps[i][31:28],
                     step_errors == 0 ? "ok" : "failed");
            i++;
        end
        tick(10);
        assert (sent_q.size() == 0) else begin
            $display("%0d rtc writes arrived that no edit asked for", sent_q.size());
            errors++;
        end
        errors += UUT.u_bank.props.fails + UUT.u_write_port.props.fails;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: sources.f
rtl/rtc_field_pkg.sv
rtl/edit_bus_pkg.sv
rtl/field_bus_if.sv
rtl/field_navigator.sv
rtl/field_register_bank.sv
rtl/rtc_write_port.sv
rtl/rtc_edit_top.sv
sim/rtc_edit_properties.sv
sim/rtc_edit_tb.sv

// File: sim/edit_testdata.txt
// kind_operand_value_address_data, kind 1 load, 2 key, 3 mode, 4 hold, 5 drain
// keys 1 inc, 2 dec, 3 left, 4 right; address is sel_address for moves
2_1_00_00_10  // inc on format
2_2_00_00_00  // dec on format
2_4_00_21_00
1_1_3b_00_00  // seconds 59
2_1_00_21_00  // wraps to 0
2_4_00_22_00
2_4_00_23_00
2_4_00_24_00
2_2_00_24_1f  // date 1 to 31
2_4_00_25_00
2_4_00_26_00
2_4_00_27_00
2_2_00_27_07  // weekday 1 to 7
2_4_00_28_00
2_4_00_00_00  // ring back to format
2_3_00_28_00
2_3_00_27_00
2_3_00_26_00
1_6_62_00_00  // year 98
2_1_00_26_63
3_1_00_41_00  // timer ring
2_4_00_42_00
2_4_00_43_00
2_4_00_41_00
4_0_00_00_00
2_1_00_00_00  // tmr_seconds to 1
2_4_00_42_00
2_1_00_00_00  // tmr_minutes to 1
3_0_00_00_00
2_4_00_21_00
2_1_00_00_00  // seconds to 1
5_0_00_41_01  // already presented
5_0_00_21_01
5_0_00_42_01
